//--- dv/codecCfgTb.sv
// Expects the ten-entry register table and a tick divider small enough for the timeouts
`include "codecCfg_settings.svh"

module codecCfgTb
	import codecCfgPkg::*;
();

	localparam int rowCount   = 12;                    // Ten entries plus two retries
	localparam int frameLimit = 200 * `CFG_TICK_DIV;   // Clocks per frame wait
	localparam int idleWindow = 300 * `CFG_TICK_DIV;   // Quiet bus after cfgDone
	localparam int riseCount  = 28;                    // 27 data/ack pulses plus the stop clock

	typedef struct packed
	{
		cfgFrame_t frm;    // Bytes expected on the bus
		logic      nack;   // Target NACKs this attempt
	} expRow_t;

	typedef struct packed
	{
		cfgFrame_t  frm;          // Bytes seen between start and stop
		logic [5:0] rises;        // scl rising edges in the frame
		logic       doneAtStop;   // cfgDone when stop was seen
	} capFrame_t;

	logic iCLK;
	logic iRST_N;
	logic scl;
	wire  sda;
	logic cfgDone;
	logic tgtPullLow;   // Target pulls sda low

	expRow_t     expTab [rowCount];
	capFrame_t   capQ [$];      // One entry per stop condition
	logic        sclPrev;
	logic        sdaPrev;
	logic        inFrame;
	logic [27:0] raw;           // Every sample taken on scl rising
	logic [5:0]  rises;
	logic        nackThis;
	int          startCount;

	codecCfgTop u_dut (.iCLK(iCLK), .iRST_N(iRST_N), .scl(scl), .sda(sda), .cfgDone(cfgDone));

	pullup (sda);
	assign sda = tgtPullLow ? 1'b0 : 1'bz;   // Open drain like the DUT

	initial
	begin
		iCLK = 1'b0;
		forever #20 iCLK = ~iCLK;
	end

	function automatic logic [15:0] regWordOf(input logic [6:0] regNum, input logic [8:0] data);
		return {regNum, data};   // Register number above 9 data bits
	endfunction

	task automatic abortRun;
		$display("Checks failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic showMismatch(input string sigName, input logic [31:0] expVal,
		input logic [31:0] gotVal);
		$display("Mismatch at time %0t: %s expected %0h, got %0h",
			$time, sigName, expVal, gotVal);
		abortRun();
	endtask

	task automatic timedOut(input string what);
		$display("Timed out at time %0t while waiting for %s", $time, what);
		abortRun();
	endtask

	task automatic waitForFrames(input int n);
		int cyc;
		cyc = 0;
		while ((capQ.size() < n) && (cyc < frameLimit))
		begin
			@(negedge iCLK);
			cyc++;
		end
		if (capQ.size() < n)
			timedOut($sformatf("bus frame %0d", n - 1));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus target model sampled on iCLK since scl only moves there

	always @(posedge iCLK)
	begin
		sclPrev <= scl;
		sdaPrev <= sda;
		if (sclPrev && scl && sdaPrev && !sda)
		begin
			inFrame    <= 1'b1;   // Start
			rises      <= '0;
			nackThis   <= (startCount < rowCount) && expTab[startCount].nack;
			startCount <= startCount + 1;
		end
		else if (inFrame && sclPrev && scl && !sdaPrev && sda)
		begin
			inFrame <= 1'b0;   // Stop with ack samples at 19, 10 and 1 dropped
			capQ.push_back({raw[27:20], raw[18:11], raw[9:2], rises, cfgDone});
		end
		else if (inFrame && !sclPrev && scl)
		begin
			raw   <= {raw[26:0], sda};
			rises <= rises + 6'd1;
		end
		else if (inFrame && sclPrev && !scl)
			tgtPullLow <= ((rises % 9) == 8) && !nackThis;   // NACK leaves it to the pull-up
	end

	//////////////////////////////////////////////////////////////////////
	// Expected writes and checking

	initial
	begin
		capFrame_t cap;
		int        cyc;
		iRST_N     = 1'b0;
		tgtPullLow = 1'b0;
		sclPrev    = 1'b1;
		sdaPrev    = 1'b1;
		inFrame    = 1'b0;
		startCount = 0;
		expTab[0]  = {`CFG_DEV_ADDR, regWordOf(7'd0, 9'h01A), 1'b0};   // Left line-in
		expTab[1]  = {`CFG_DEV_ADDR, regWordOf(7'd1, 9'h01A), 1'b0};   // Right line-in
		expTab[2]  = {`CFG_DEV_ADDR, regWordOf(7'd2, 9'h07B), 1'b1};   // Left headphone NACKed
		expTab[3]  = {`CFG_DEV_ADDR, regWordOf(7'd2, 9'h07B), 1'b0};   // Same entry resent
		expTab[4]  = {`CFG_DEV_ADDR, regWordOf(7'd3, 9'h07B), 1'b0};   // Right headphone
		expTab[5]  = {`CFG_DEV_ADDR, regWordOf(7'd4, 9'h0F8), 1'b0};   // Analog path
		expTab[6]  = {`CFG_DEV_ADDR, regWordOf(7'd5, 9'h006), 1'b0};   // Digital path
		expTab[7]  = {`CFG_DEV_ADDR, regWordOf(7'd6, 9'h000), 1'b1};   // Power NACKed
		expTab[8]  = {`CFG_DEV_ADDR, regWordOf(7'd6, 9'h000), 1'b0};
		expTab[9]  = {`CFG_DEV_ADDR, regWordOf(7'd7, 9'h001), 1'b0};   // Interface format
		expTab[10] = {`CFG_DEV_ADDR, regWordOf(7'd8, 9'h009), 1'b0};   // Sampling
		expTab[11] = {`CFG_DEV_ADDR, regWordOf(7'd9, 9'h001), 1'b0};   // Active
		repeat (2) @(posedge iCLK);
		iRST_N <= 1'b1;
		@(negedge iCLK);
		// Still ahead of the first tick
		assert (scl === 1'b1) else showMismatch("scl", 1, scl);
		assert (sda === 1'b1) else showMismatch("sda", 1, sda);
		assert (cfgDone === 1'b0) else showMismatch("cfgDone", 0, cfgDone);
		for (int r = 0; r < rowCount; r++)
		begin
			waitForFrames(r + 1);
			cap = capQ[r];
			assert (cap.frm.devAddr == expTab[r].frm.devAddr)
				else showMismatch("devAddr", expTab[r].frm.devAddr, cap.frm.devAddr);
			assert (cap.frm.regWord == expTab[r].frm.regWord)
				else showMismatch("regWord", expTab[r].frm.regWord, cap.frm.regWord);
			assert (cap.rises == riseCount) else showMismatch("scl rises", riseCount, cap.rises);
			assert (cap.doneAtStop == 1'b0) else showMismatch("cfgDone", 0, cap.doneAtStop);
		end
		cyc = 0;
		while (!cfgDone && (cyc < frameLimit))
		begin
			@(negedge iCLK);
			cyc++;
		end
		if (!cfgDone)
			timedOut("cfgDone after the last frame");
		repeat (idleWindow)
		begin
			@(negedge iCLK);
			assert (cfgDone === 1'b1) else showMismatch("cfgDone", 1, cfgDone);
		end
		assert (startCount == rowCount) else showMismatch("start count", rowCount, startCount);
		if (u_dut.u_writeEngine.u_checker.failCount == 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
		begin
			$display("Bound protocol assertions fired %0d times",
				u_dut.u_writeEngine.u_checker.failCount);
			abortRun();
		end
	end

endmodule

//--- dv/codecCfg_checker.sv
// Watches one write engine on iCLK only, with sdaIn taken as the raw pin including the target's drive
module codecCfgChecker
	import codecCfgPkg::*;
(
	input logic       iCLK,
	input logic       iRST_N,
	input engPhase_t  phase,    // Engine state
	input logic       scl,
	input logic       sdaIn,    // Bus data as seen on the pin
	input engStatus_t status
);

	int unsigned doneErrs = 0;   // Failures per property
	int unsigned sdaErrs  = 0;
	int unsigned idleErrs = 0;
	int unsigned failCount;      // Total over all properties

	assign failCount = doneErrs + sdaErrs + idleErrs;

	//////////////////////////////////////////////////////////////////////
	// Engine protocol

	aDonePulse: assert property (@(posedge iCLK) disable iff (!iRST_N)
		status.done |=> !status.done)
	else
	begin
		$error("Engine done stayed high for two cycles");
		doneErrs = doneErrs + 1;
	end

	// Data moves under high scl only for start and stop
	aSdaStable: assert property (@(posedge iCLK) disable iff (!iRST_N)
		(scl && $past(scl) && !$stable(sdaIn)) |-> (phase inside {phStart, phStop}))
	else
	begin
		$error("sda changed under high scl outside start and stop");
		sdaErrs = sdaErrs + 1;
	end

	aIdleScl: assert property (@(posedge iCLK) disable iff (!iRST_N)
		(phase == phIdle) |-> scl)   // Bus parked high
	else
	begin
		$error("scl low while the engine is idle");
		idleErrs = idleErrs + 1;
	end

endmodule

bind i2cWriteEngine codecCfgChecker u_checker
(
	.iCLK(iCLK), .iRST_N(iRST_N), .phase(phase), .scl(scl), .sdaIn(sdaIn), .status(status)
);

//--- include/codecCfg_settings.svh
// Simulation values by default, and CFG_TICK_DIV must stay at 2 or more for the go/done timing to hold
`ifndef CODECCFG_SETTINGS_SVH
`define CODECCFG_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Bus timing

// System clocks per quarter-bit phase
// Use about 300 for 24 MHz in and a 20 kHz bus
`define CFG_TICK_DIV 4

//////////////////////////////////////////////////////////////////////
// Codec addressing and table

`define CFG_DEV_ADDR 8'h34   // Codec write address, CSB low
`define CFG_TABLE_LEN 10     // Register words sent after reset
`define CFG_IDX_W 4          // Wide enough to hold CFG_TABLE_LEN itself

`endif

//--- rtl/cfgRegTable.sv
// Fixed power-up words for the codec, so any index at or past CFG_TABLE_LEN reads back zero
`include "codecCfg_settings.svh"

module cfgRegTable
(
	input  logic [`CFG_IDX_W-1:0] idx,       // Entry number from the sequencer
	output logic [15:0]           regWord    // {reg[6:0], data[8:0]}
);

	localparam int unsigned idxW = `CFG_IDX_W;
	localparam logic [idxW-1:0] tableLen = idxW'(`CFG_TABLE_LEN);

	//////////////////////////////////////////////////////////////////////
	// Register words

	always_comb
	begin
		regWord = 16'h0000;
		if (idx < tableLen)
		begin
			case (idx)
				4'd0:    regWord = 16'h001A;   // R0 left line-in, 1Ah
				4'd1:    regWord = 16'h021A;   // R1 right line-in, 1Ah
				4'd2:    regWord = 16'h047B;   // R2 left headphone, 7Bh
				4'd3:    regWord = 16'h067B;   // R3 right headphone, 7Bh
				4'd4:    regWord = 16'h08F8;   // R4 analog path, DAC selected
				4'd5:    regWord = 16'h0A06;   // R5 de-emphasis at 48 kHz
				4'd6:    regWord = 16'h0C00;   // R6 every block powered
				4'd7:    regWord = 16'h0E01;   // R7 left-justified, 16 bit
				4'd8:    regWord = 16'h1009;   // R8 48 kHz, USB mode
				4'd9:    regWord = 16'h1201;   // R9 interface active
				default: regWord = 16'h0000;
			endcase
		end
	end

	// Activation goes last
	// The codec expects the format and sampling words before it

endmodule

//--- rtl/cfgSequencer.sv
// Retries a NACKed entry forever with no limit, and after the last entry it idles until reset
`include "codecCfg_settings.svh"

module cfgSequencer
	import codecCfgPkg::*;
(
	input  logic                  iCLK,
	input  logic                  iRST_N,
	input  logic [15:0]           regWord,   // Table word at idx, same cycle
	input  engStatus_t            status,    // done pulse with nack
	output logic [`CFG_IDX_W-1:0] idx,       // Current table entry
	output cfgFrame_t             frame,     // Held stable while go is high
	output logic                  go,        // Write request level
	output logic                  cfgDone    // Sticky until reset
);

	localparam int unsigned idxW = `CFG_IDX_W;
	localparam logic [idxW-1:0] tableLen = idxW'(`CFG_TABLE_LEN);

	typedef enum logic [1:0]
	{
		sLoad,      // Build frame and raise go
		sWait,      // Engine busy
		sAdvance    // Next entry or finish
	} seqState_t;

	seqState_t state;
	logic      loadFrame;   // Frame register enable

	// A write starts from load (first entry, retry) or from advance (next entry)
	assign loadFrame = (state == sLoad) || ((state == sAdvance) && (idx != tableLen));

	//////////////////////////////////////////////////////////////////////
	// Frame register

	always_ff @(posedge iCLK)
	begin
		if (loadFrame)
		begin
			frame.devAddr <= `CFG_DEV_ADDR;
			frame.regWord <= regWord;   // Same word again on a retry
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			state   <= sLoad;
			idx     <= '0;
			go      <= 1'b0;
			cfgDone <= 1'b0;
		end
		else
		begin
			case (state)
				sLoad:
				begin
					go    <= 1'b1;
					state <= sWait;
				end
				sWait:
				begin
					if (status.done)
					begin
						go <= 1'b0;   // Low the cycle after done
						if (status.nack)
							state <= sLoad;   // Resend same idx
						else
						begin
							idx   <= idx + 1'b1;
							state <= sAdvance;
						end
					end
				end
				sAdvance:
				begin
					if (idx == tableLen)
						cfgDone <= 1'b1;   // Stays here until reset
					else
					begin
						go    <= 1'b1;
						state <= sWait;
					end
				end
				default: state <= sLoad;
			endcase
		end
	end

endmodule

//--- rtl/codecCfgPkg.sv
// Shared types assume one fixed 24-bit frame per bus write and a five-phase engine
package codecCfgPkg;

	//////////////////////////////////////////////////////////////////////
	// Payload of one bus write

	// Sent MSB first, device byte then the register word high byte first
	typedef struct packed
	{
		logic [7:0]  devAddr;   // Write address byte, R/W bit already 0
		logic [15:0] regWord;   // Register number [15:9], data [8:0]
	} cfgFrame_t;

	//////////////////////////////////////////////////////////////////////
	// Engine to sequencer

	typedef struct packed
	{
		logic done;   // One cycle at the end of a frame
		logic nack;   // Valid with done
	} engStatus_t;

	// Bit-level engine phases
	typedef enum logic [2:0]
	{
		phIdle,    // scl high, sda released
		phStart,   // sda falls under high scl
		phBit,     // One data bit per four ticks
		phAck,     // sda released and sampled
		phStop     // sda rises under high scl
	} engPhase_t;

endpackage

//--- rtl/codecCfgTop.sv
// Needs an external pull-up on sda, and scl is driven push-pull so the target cannot stretch it
`include "codecCfg_settings.svh"

module codecCfgTop
	import codecCfgPkg::*;
(
	input  logic iCLK,
	input  logic iRST_N,
	output logic scl,       // Bus clock
	inout  wire  sda,       // Bus data, open drain
	output logic cfgDone    // Codec configured
);

	logic                  tick;
	logic [`CFG_IDX_W-1:0] idx;
	logic [15:0]           regWord;
	cfgFrame_t             frame;
	logic                  go;
	engStatus_t            status;
	logic                  sdaDriveLow;
	logic                  sdaIn;

	//////////////////////////////////////////////////////////////////////
	// Pin

	assign sda   = sdaDriveLow ? 1'b0 : 1'bz;   // Pull-down or float
	assign sdaIn = sda;

	//////////////////////////////////////////////////////////////////////
	// Blocks

	i2cTickTimer u_tickTimer (.iCLK(iCLK), .iRST_N(iRST_N), .tick(tick));

	cfgRegTable u_regTable (.idx(idx), .regWord(regWord));

	cfgSequencer u_sequencer
	(
		.iCLK(iCLK), .iRST_N(iRST_N), .regWord(regWord), .status(status),
		.idx(idx), .frame(frame), .go(go), .cfgDone(cfgDone)
	);

	i2cWriteEngine u_writeEngine
	(
		.iCLK(iCLK), .iRST_N(iRST_N), .tick(tick), .go(go), .frame(frame),
		.sdaIn(sdaIn), .scl(scl), .sdaDriveLow(sdaDriveLow), .status(status)
	);

endmodule

//--- rtl/i2cTickTimer.sv
// Free-running from reset release with no enable, so the first tick lands CFG_TICK_DIV clocks later
`include "codecCfg_settings.svh"

module i2cTickTimer
(
	input  logic iCLK,
	input  logic iRST_N,
	output logic tick      // One-cycle quarter-phase enable
);

	// One spare bit keeps the width non-zero for small dividers
	localparam int unsigned cntW = $clog2(`CFG_TICK_DIV) + 1;
	localparam logic [cntW-1:0] cntLast = cntW'(`CFG_TICK_DIV - 1);

	logic [cntW-1:0] cnt;   // Divider count

	//////////////////////////////////////////////////////////////////////
	// Divider

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			cnt  <= '0;
			tick <= 1'b0;
		end
		else
		begin
			tick <= 1'b0;   // Pulse only on wrap
			if (cnt == cntLast)
			begin
				cnt  <= '0;
				tick <= 1'b1;
			end
			else
				cnt <= cnt + 1'b1;
		end
	end

endmodule

//--- rtl/i2cWriteEngine.sv
// Write-only bus master with no clock stretching, arbitration or reads, and go is sampled on ticks only
module i2cWriteEngine
	import codecCfgPkg::*;
(
	input  logic       iCLK,
	input  logic       iRST_N,
	input  logic       tick,          // Quarter-bit enable
	input  logic       go,            // Start request level
	input  cfgFrame_t  frame,         // Latched when leaving idle
	input  logic       sdaIn,         // Pin read back
	output logic       scl,           // Push-pull clock
	output logic       sdaDriveLow,   // Open-drain pull-down
	output engStatus_t status
);

	localparam logic [2:0] lastBit  = 3'd7;
	localparam logic [1:0] lastByte = 2'd2;

	engPhase_t   phase;
	logic [1:0]  qCnt;       // Quarter within a bit or condition
	logic [2:0]  bitCnt;     // Bit within the byte
	logic [1:0]  byteCnt;    // Byte within the frame
	logic [23:0] shReg;      // Outgoing bits, MSB at [23]
	logic        nackSeen;   // Any byte unacknowledged
	logic [1:0]  sdaSync;    // Pin synchronizer

	//////////////////////////////////////////////////////////////////////
	// Input sync and shifter

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
			sdaSync <= 2'b11;   // Idle bus reads high
		else
			sdaSync <= {sdaSync[0], sdaIn};
	end

	always_ff @(posedge iCLK)
	begin
		if (tick)
		begin
			if ((phase == phIdle) && go)
				shReg <= frame;
			else if ((phase == phBit) && (qCnt == 2'd3))
				shReg <= {shReg[22:0], 1'b0};   // Next bit to [23]
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Phase FSM
	// Quarter 0 raises scl, 2 drops it, 3 sets the next data bit

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			phase       <= phIdle;
			qCnt        <= 2'd0;
			bitCnt      <= 3'd0;
			byteCnt     <= 2'd0;
			nackSeen    <= 1'b0;
			scl         <= 1'b1;
			sdaDriveLow <= 1'b0;
			status      <= '0;
		end
		else
		begin
			status.done <= 1'b0;   // Pulse
			if (tick)
			begin
				qCnt <= qCnt + 2'd1;   // Wraps every four ticks
				case (phase)
					phIdle:
					begin
						qCnt <= 2'd0;
						if (go)
						begin
							phase    <= phStart;
							bitCnt   <= 3'd0;
							byteCnt  <= 2'd0;
							nackSeen <= 1'b0;
						end
					end
					phStart:
					begin
						case (qCnt)
							2'd0: sdaDriveLow <= 1'b1;   // Start condition
							2'd1: scl <= 1'b1;           // Hold under high scl
							2'd2: scl <= 1'b0;
							default:
							begin
								sdaDriveLow <= ~shReg[23];   // First MSB
								phase       <= phBit;
							end
						endcase
					end
					phBit:
					begin
						case (qCnt)
							2'd0: scl <= 1'b1;
							2'd1: scl <= 1'b1;   // Data held
							2'd2: scl <= 1'b0;
							default:
							begin
								if (bitCnt == lastBit)
								begin
									bitCnt      <= 3'd0;
									sdaDriveLow <= 1'b0;   // Release for ack
									phase       <= phAck;
								end
								else
								begin
									bitCnt      <= bitCnt + 3'd1;
									sdaDriveLow <= ~shReg[22];   // Bit after the shift
								end
							end
						endcase
					end
					phAck:
					begin
						case (qCnt)
							2'd0: scl <= 1'b1;
							2'd1:
							begin
								if (sdaSync[1])
									nackSeen <= 1'b1;   // Target left sda high
							end
							2'd2: scl <= 1'b0;
							default:
							begin
								if (byteCnt == lastByte)
								begin
									sdaDriveLow <= 1'b1;   // Low before stop
									phase       <= phStop;
								end
								else
								begin
									byteCnt     <= byteCnt + 2'd1;
									sdaDriveLow <= ~shReg[23];   // Next byte MSB
									phase       <= phBit;
								end
							end
						endcase
					end
					phStop:
					begin
						case (qCnt)
							2'd0: scl <= 1'b1;
							2'd1: sdaDriveLow <= 1'b0;   // Stop condition
							2'd2: scl <= 1'b1;
							default:
							begin
								phase       <= phIdle;
								status.done <= 1'b1;
								status.nack <= nackSeen;
							end
						endcase
					end
					default: phase <= phIdle;
				endcase
			end
		end
	end

endmodule

//--- tb.f
+incdir+include
rtl/codecCfgPkg.sv
rtl/i2cTickTimer.sv
rtl/cfgRegTable.sv
rtl/cfgSequencer.sv
rtl/i2cWriteEngine.sv
rtl/codecCfgTop.sv
dv/codecCfg_checker.sv
dv/codecCfgTb.sv
